// File: dualIssueCore.f
+incdir+verilog
verilog/dualIssuePkg.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/executeLane.sv
verilog/dualIssueCore.sv
dv/dualIssueCoreTb.sv

// File: dv/dualIssueTrace.txt
# name instrA instrB | laneA: valid destReg data | laneB: valid destReg data
# all values hex, expected results from an all-zero register file in program order
addi_sign 20010005 2002fffe 1 01 00000005 1 02 fffffffe
ori_andi 34038001 3044ff0f 1 03 00008001 1 04 0000ff0e
xori_lui 3825ffff 3c068765 1 05 0000fffa 1 06 87650000
slti_signed 28470001 2828ffff 1 07 00000001 1 08 00000000
add_sub 00264820 00225022 1 09 87650005 1 0a 00000007
and_or 01245824 00ca6025 1 0b 00000004 1 0c 87650007
xor_nor 01856826 00037027 1 0d 8765fffd 1 0e ffff7ffe
slt_sll 01c1782a 00018100 1 0f 00000001 1 10 00000050
srl_slt 00068c02 002e902a 1 11 00008765 1 12 00000000
same_dest 20130011 20130022 1 13 00000011 1 13 00000022
fwd_b_priority 0260a020 22750001 1 14 00000022 1 15 00000023
same_pair_old 20210100 0020b020 1 01 00000105 1 16 00000005
independent 34171234 381800ff 1 17 00001234 1 18 000000ff
write_through 0036c822 0277d025 1 19 00000100 1 1a 00001236
dest_r0 20200007 00210020 0 00 00000000 0 00 00000000
unknown_enc fc210001 0021d83f 0 00 00000000 0 00 00000000
r0_reads_zero 0001e820 0360e025 1 1d 00000105 1 1c 00000000
andi_ori_swap 31bef0f0 363f1000 1 1e 0000f0f0 1 1f 00009765
lui_and_swap 3c02ffff 03df1824 1 02 ffff0000 1 03 00009060
or_xor_swap 00432025 005f2826 1 04 ffff9060 1 05 ffff9765
nor_srl_swap 00803027 00023a02 1 06 00006f9f 1 07 00ffff00
sll_add_swap 00054300 00c74820 1 08 f9765000 1 09 01006e9f
add_wrap 01085020 00015822 1 0a f2eca000 1 0b fffffefb
lane_b_bubble 216c0105 04210003 1 0c 00000000 0 00 00000000
final_read 01936820 016c702a 1 0d 00000022 1 0e 00000001

// File: dv/dualIssueCoreTb.sv
`timescale 1ns/1ps
`include "dualIssue_macros.svh"

module dualIssueCoreTb;

    localparam int RESET_CYCLES = 10;

    logic                    clk;
    logic                    reset;
    logic                    issueValid;
    dualIssuePkg::issuePairT issuePair;
    dualIssuePkg::wbPortT    wbA;
    dualIssuePkg::wbPortT    wbB;

    // contents of the trace file
    string                   testNames[$];
    dualIssuePkg::issuePairT tracePairs[$];
    dualIssuePkg::wbPortT    traceA[$];
    dualIssuePkg::wbPortT    traceB[$];

    // one entry per driven cycle, oldest first
    string                   pendName[$];
    dualIssuePkg::wbPortT    pendA[$];
    dualIssuePkg::wbPortT    pendB[$];

    int          valueErrors = 0;
    int          otherErrors = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    logic [31:0] rngState = 32'd61735;

    dualIssueCore UUT (
        .clk        (clk),
        .reset      (reset),
        .issueValid (issueValid),
        .issuePair  (issuePair),
        .wbA        (wbA),
        .wbB        (wbB)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("run stopped after %0d cycles without finishing", cycleCount);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic loadTrace();
        int                         fd;
        int                         fields;
        string                      line;
        string                      name;
        logic [31:0]                wordA;
        logic [31:0]                wordB;
        logic                       validA;
        logic                       validB;
        logic [`REG_ADDR_WIDTH-1:0] destA;
        logic [`REG_ADDR_WIDTH-1:0] destB;
        logic [`DATA_WIDTH-1:0]     dataA;
        logic [`DATA_WIDTH-1:0]     dataB;
        dualIssuePkg::issuePairT    pair;
        dualIssuePkg::wbPortT       expA;
        dualIssuePkg::wbPortT       expB;
        fd = $fopen("dv/dualIssueTrace.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("cannot open trace file dv/dualIssueTrace.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 4 || line.substr(0, 0) == "#")
                continue;
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, wordA, wordB,
                             validA, destA, dataA, validB, destB, dataB);
            if (fields != 9) begin
                otherErrors++;
                $display("trace line could not be parsed: %s", line);
                continue;
            end
            pair = {wordA, wordB};
            expA = {validA, destA, dataA};
            expB = {validB, destB, dataB};
            testNames.push_back(name);
            tracePairs.push_back(pair);
            traceA.push_back(expA);
            traceB.push_back(expB);
        end
        $fclose(fd);
    endtask

    task automatic checkWb(input string testName, input string lane,
                           input dualIssuePkg::wbPortT expected,
                           input dualIssuePkg::wbPortT actual);
        logic mismatch;
        // with no write-back expected only the valid bit is defined
        if (expected.valid)
            mismatch = (actual !== expected);
        else
            mismatch = (actual.valid !== 1'b0);
        if (mismatch) begin
            valueErrors++;
            $display("ERR %s lane %s: expected v=%0b d=%0d %h, actual v=%0b d=%0d %h",
                     testName, lane, expected.valid, expected.destReg, expected.data,
                     actual.valid, actual.destReg, actual.data);
        end
    endtask

    // entry driven three cycles ago is on the write-back ports now
    task automatic retireOldest();
        if (pendName.size() > 0) begin
            checkWb(pendName[0], "A", pendA[0], wbA);
            checkWb(pendName[0], "B", pendB[0], wbB);
            void'(pendName.pop_front());
            void'(pendA.pop_front());
            void'(pendB.pop_front());
        end
    endtask

    task automatic driveCycle(input logic valid, input dualIssuePkg::issuePairT pair,
                              input string name, input dualIssuePkg::wbPortT expA,
                              input dualIssuePkg::wbPortT expB);
        @(negedge clk);
        retireOldest();
        issueValid = valid;
        issuePair  = pair;
        pendName.push_back(name);
        pendA.push_back(expA);
        pendB.push_back(expB);
    endtask

    initial begin
        dualIssuePkg::wbPortT noWb;
        int                   gap;
        noWb       = '0;
        reset      = 1'b1;
        issueValid = 1'b0;
        issuePair  = '0;
        loadTrace();
        if (tracePairs.size() == 0 && otherErrors == 0) begin
            otherErrors++;
            $display("trace file holds no instruction pairs");
        end
        cycleLimit = tracePairs.size() * 4 + 3 + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // the first three cycles out of reset must be quiet
        repeat (3) begin
            pendName.push_back("reset");
            pendA.push_back(noWb);
            pendB.push_back(noWb);
        end

        for (int i = 0; i < tracePairs.size(); i++) begin
            driveCycle(1'b1, tracePairs[i], testNames[i], traceA[i], traceB[i]);
            rngState = nextRandom(rngState);
            gap = rngState[1:0];
            repeat (gap) driveCycle(1'b0, '0, "idle", noWb, noWb);
        end

        repeat (3) begin
            @(negedge clk);
            retireOldest();
            issueValid = 1'b0;
        end
        if (pendName.size() != 0) begin
            otherErrors++;
            $display("%0d expected write-backs never came out", pendName.size());
        end

        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verilog/dualIssueCore.sv
`timescale 1ns/1ps
`include "dualIssue_macros.svh"

module dualIssueCore (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issueValid,
    input  dualIssuePkg::issuePairT issuePair,
    output dualIssuePkg::wbPortT    wbA,
    output dualIssuePkg::wbPortT    wbB
);

    // decode stage
    logic                    decodeValid;
    dualIssuePkg::issuePairT decodePair;
    dualIssuePkg::laneCtrlT  decCtrlA;
    dualIssuePkg::laneCtrlT  decCtrlB;
    dualIssuePkg::laneCtrlT  liveCtrlA;
    dualIssuePkg::laneCtrlT  liveCtrlB;
    logic [`DATA_WIDTH-1:0]  readDataA0;
    logic [`DATA_WIDTH-1:0]  readDataA1;
    logic [`DATA_WIDTH-1:0]  readDataB0;
    logic [`DATA_WIDTH-1:0]  readDataB1;

    // execute stage
    dualIssuePkg::laneCtrlT  exCtrlA;
    dualIssuePkg::laneCtrlT  exCtrlB;
    logic [`DATA_WIDTH-1:0]  exOpA0;
    logic [`DATA_WIDTH-1:0]  exOpA1;
    logic [`DATA_WIDTH-1:0]  exOpB0;
    logic [`DATA_WIDTH-1:0]  exOpB1;
    dualIssuePkg::wbPortT    laneResultA;
    dualIssuePkg::wbPortT    laneResultB;

    always_ff @(posedge clk) begin
        if (reset) begin
            decodeValid <= 1'b0;
        end else begin
            decodeValid <= issueValid;
            if (issueValid)
                decodePair <= issuePair;
        end
    end

    instrDecoder decoderA (
        .instr (decodePair.instrA),
        .ctrl  (decCtrlA)
    );

    instrDecoder decoderB (
        .instr (decodePair.instrB),
        .ctrl  (decCtrlB)
    );

    // idle cycles become bubbles
    always_comb begin
        liveCtrlA       = decCtrlA;
        liveCtrlA.valid = decCtrlA.valid & decodeValid;
        liveCtrlB       = decCtrlB;
        liveCtrlB.valid = decCtrlB.valid & decodeValid;
    end

    // write ports fed straight from the write-back register
    registerFile regFile (
        .clk        (clk),
        .reset      (reset),
        .readAddrA0 (decCtrlA.srcA),
        .readAddrA1 (decCtrlA.srcB),
        .readAddrB0 (decCtrlB.srcA),
        .readAddrB1 (decCtrlB.srcB),
        .readDataA0 (readDataA0),
        .readDataA1 (readDataA1),
        .readDataB0 (readDataB0),
        .readDataB1 (readDataB1),
        .writeA     (wbA),
        .writeB     (wbB)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            exCtrlA.valid <= 1'b0;
            exCtrlB.valid <= 1'b0;
        end else begin
            exCtrlA <= liveCtrlA;
            exCtrlB <= liveCtrlB;
            exOpA0  <= readDataA0;
            exOpA1  <= readDataA1;
            exOpB0  <= readDataB0;
            exOpB1  <= readDataB1;
        end
    end

    // both lanes forward only from the pair one stage ahead
    executeLane laneA (
        .ctrl     (exCtrlA),
        .operandA (exOpA0),
        .operandB (exOpA1),
        .fwdA     (wbA),
        .fwdB     (wbB),
        .result   (laneResultA)
    );

    executeLane laneB (
        .ctrl     (exCtrlB),
        .operandA (exOpB0),
        .operandB (exOpB1),
        .fwdA     (wbA),
        .fwdB     (wbB),
        .result   (laneResultB)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            wbA.valid <= 1'b0;
            wbB.valid <= 1'b0;
        end else begin
            wbA <= laneResultA;
            wbB <= laneResultB;
        end
    end

endmodule

// File: verilog/executeLane.sv
`timescale 1ns/1ps
`include "dualIssue_macros.svh"

module executeLane (
    input  dualIssuePkg::laneCtrlT     ctrl,
    input  logic [`DATA_WIDTH-1:0]     operandA,
    input  logic [`DATA_WIDTH-1:0]     operandB,
    input  dualIssuePkg::wbPortT       fwdA,
    input  dualIssuePkg::wbPortT       fwdB,
    output dualIssuePkg::wbPortT       result
);

    logic [`DATA_WIDTH-1:0] srcValA;
    logic [`DATA_WIDTH-1:0] srcValB;
    logic [`DATA_WIDTH-1:0] aluB;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic                   lessThan;

    // older pair's lane B beats its lane A, which beats the register file
    function automatic logic [`DATA_WIDTH-1:0] forwardSel(
        input logic [`REG_ADDR_WIDTH-1:0] src,
        input logic [`DATA_WIDTH-1:0]     regVal,
        input dualIssuePkg::wbPortT       fa,
        input dualIssuePkg::wbPortT       fb
    );
        if (src == '0)
            return regVal;
        else if (fb.valid && fb.destReg == src)
            return fb.data;
        else if (fa.valid && fa.destReg == src)
            return fa.data;
        else
            return regVal;
    endfunction

    assign srcValA = forwardSel(ctrl.srcA, operandA, fwdA, fwdB);
    assign srcValB = forwardSel(ctrl.srcB, operandB, fwdA, fwdB);

    // immediate already extended by the decoder
    assign aluB = ctrl.useImm ? ctrl.imm : srcValB;

    assign lessThan = $signed(srcValA) < $signed(aluB);

    always_comb begin
        case (ctrl.aluOp)
            dualIssuePkg::ALU_ADD:
                aluOut = srcValA + aluB;
            dualIssuePkg::ALU_SUB:
                aluOut = srcValA - aluB;
            dualIssuePkg::ALU_AND:
                aluOut = srcValA & aluB;
            dualIssuePkg::ALU_OR:
                aluOut = srcValA | aluB;
            dualIssuePkg::ALU_XOR:
                aluOut = srcValA ^ aluB;
            dualIssuePkg::ALU_NOR:
                aluOut = ~(srcValA | aluB);
            dualIssuePkg::ALU_SLT:
                aluOut = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
            // shifts act on rt by the shamt field
            dualIssuePkg::ALU_SLL:
                aluOut = aluB << ctrl.shamt;
            dualIssuePkg::ALU_SRL:
                aluOut = aluB >> ctrl.shamt;
            dualIssuePkg::ALU_LUI:
                aluOut = aluB;
            default:
                aluOut = '0;
        endcase
    end

    assign result = '{
        valid:   ctrl.valid,
        destReg: ctrl.destReg,
        data:    aluOut
    };

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps
`include "dualIssue_macros.svh"

module registerFile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrA0,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrA1,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrB0,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrB1,
    output logic [`DATA_WIDTH-1:0]     readDataA0,
    output logic [`DATA_WIDTH-1:0]     readDataA1,
    output logic [`DATA_WIDTH-1:0]     readDataB0,
    output logic [`DATA_WIDTH-1:0]     readDataB1,
    input  dualIssuePkg::wbPortT       writeA,
    input  dualIssuePkg::wbPortT       writeB
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // write-through, the younger lane B checked first
    function automatic logic [`DATA_WIDTH-1:0] readPort(
        input logic [`REG_ADDR_WIDTH-1:0] addr,
        input logic [`DATA_WIDTH-1:0]     stored,
        input dualIssuePkg::wbPortT       wa,
        input dualIssuePkg::wbPortT       wb
    );
        if (addr == '0)
            return '0;
        else if (wb.valid && wb.destReg == addr)
            return wb.data;
        else if (wa.valid && wa.destReg == addr)
            return wa.data;
        else
            return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else begin
            if (writeA.valid && writeA.destReg != '0)
                regs[writeA.destReg] <= writeA.data;
            // last assignment wins, so lane B owns a shared address
            if (writeB.valid && writeB.destReg != '0)
                regs[writeB.destReg] <= writeB.data;
        end
    end

    assign readDataA0 = readPort(readAddrA0, regs[readAddrA0], writeA, writeB);
    assign readDataA1 = readPort(readAddrA1, regs[readAddrA1], writeA, writeB);
    assign readDataB0 = readPort(readAddrB0, regs[readAddrB0], writeA, writeB);
    assign readDataB1 = readPort(readAddrB1, regs[readAddrB1], writeA, writeB);

endmodule

// File: verilog/instrDecoder.sv
`timescale 1ns/1ps
`include "dualIssue_macros.svh"

module instrDecoder (
    input  dualIssuePkg::instrT    instr,
    output dualIssuePkg::laneCtrlT ctrl
);

    logic                   known;
    logic [`DATA_WIDTH-1:0] signImm;
    logic [`DATA_WIDTH-1:0] zeroImm;
    logic [`DATA_WIDTH-1:0] upperImm;

    assign signImm  = {{(`DATA_WIDTH-16){instr.i.imm[15]}}, instr.i.imm};
    assign zeroImm  = {{(`DATA_WIDTH-16){1'b0}}, instr.i.imm};
    assign upperImm = {instr.i.imm, {(`DATA_WIDTH-16){1'b0}}};

    always_comb begin
        known       = 1'b1;
        ctrl        = '0;
        ctrl.aluOp  = dualIssuePkg::ALU_ADD;
        // rs and rt sit at the same bits in both layouts
        ctrl.srcA   = instr.r.rs;
        ctrl.srcB   = instr.r.rt;

        if (instr.r.opcode == `OP_RTYPE) begin
            ctrl.destReg = instr.r.rd;
            ctrl.shamt   = instr.r.shamt;
            case (instr.r.funct)
                `FN_ADD: ctrl.aluOp = dualIssuePkg::ALU_ADD;
                `FN_SUB: ctrl.aluOp = dualIssuePkg::ALU_SUB;
                `FN_AND: ctrl.aluOp = dualIssuePkg::ALU_AND;
                `FN_OR:  ctrl.aluOp = dualIssuePkg::ALU_OR;
                `FN_XOR: ctrl.aluOp = dualIssuePkg::ALU_XOR;
                `FN_NOR: ctrl.aluOp = dualIssuePkg::ALU_NOR;
                `FN_SLT: ctrl.aluOp = dualIssuePkg::ALU_SLT;
                `FN_SLL: ctrl.aluOp = dualIssuePkg::ALU_SLL;
                `FN_SRL: ctrl.aluOp = dualIssuePkg::ALU_SRL;
                default: known = 1'b0;
            endcase
        end else begin
            ctrl.destReg = instr.i.rt;
            ctrl.useImm  = 1'b1;
            case (instr.i.opcode)
                `OP_ADDI: begin
                    ctrl.aluOp = dualIssuePkg::ALU_ADD;
                    ctrl.imm   = signImm;
                end
                `OP_SLTI: begin
                    ctrl.aluOp = dualIssuePkg::ALU_SLT;
                    ctrl.imm   = signImm;
                end
                `OP_ANDI: begin
                    ctrl.aluOp = dualIssuePkg::ALU_AND;
                    ctrl.imm   = zeroImm;
                end
                `OP_ORI: begin
                    ctrl.aluOp = dualIssuePkg::ALU_OR;
                    ctrl.imm   = zeroImm;
                end
                `OP_XORI: begin
                    ctrl.aluOp = dualIssuePkg::ALU_XOR;
                    ctrl.imm   = zeroImm;
                end
                `OP_LUI: begin
                    ctrl.aluOp = dualIssuePkg::ALU_LUI;
                    ctrl.imm   = upperImm;
                end
                default: known = 1'b0;
            endcase
        end

        // writes to r0 are dropped here so nothing downstream has to check
        ctrl.valid = known && (ctrl.destReg != '0);
    end

endmodule

// File: verilog/dualIssuePkg.sv
`include "dualIssue_macros.svh"

package dualIssuePkg;

    // R-type field layout
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                 shamt;
        logic [5:0]                 funct;
    } rTypeT;

    // I-type field layout
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [15:0]                imm;
    } iTypeT;

    // one instruction word, viewed either way
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } aluOpT;

    // decoded lane, valid only for instructions that write a register
    typedef struct packed {
        logic                       valid;
        aluOpT                      aluOp;
        logic                       useImm;
        logic [4:0]                 shamt;
        logic [`REG_ADDR_WIDTH-1:0] srcA;
        logic [`REG_ADDR_WIDTH-1:0] srcB;
        logic [`REG_ADDR_WIDTH-1:0] destReg;
        logic [`DATA_WIDTH-1:0]     imm;
    } laneCtrlT;

    // instrA is the older of the two
    typedef struct packed {
        instrT instrA;
        instrT instrB;
    } issuePairT;

    typedef struct packed {
        logic                       valid;
        logic [`REG_ADDR_WIDTH-1:0] destReg;
        logic [`DATA_WIDTH-1:0]     data;
    } wbPortT;

endpackage

// File: verilog/dualIssue_macros.svh
`ifndef DUAL_ISSUE_MACROS_SVH
`define DUAL_ISSUE_MACROS_SVH

// datapath and register file sizes
`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 5
`define REG_COUNT      32

// primary opcodes, standard MIPS values
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_SLTI  6'h0A
`define OP_ANDI  6'h0C
`define OP_ORI   6'h0D
`define OP_XORI  6'h0E
`define OP_LUI   6'h0F

// function codes used when the opcode is R-type
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_XOR 6'h26
`define FN_NOR 6'h27
`define FN_SLT 6'h2A

`endif
